// File: hdl/nibble_params.svh
// Nibble datapath sizes
`ifndef NIBBLE_PARAMS_SVH
`define NIBBLE_PARAMS_SVH

// bits in one nibble
`define NIBBLE_W 4

// nibbles in one operand word
`define NIBBLE_CNT 8

// nibble index and last-index field
`define IDX_W 3

// full operand and result word
`define WORD_W (`NIBBLE_W * `NIBBLE_CNT)

`endif

// File: hdl/alu_pkg.sv
// Nibble ALU types
`default_nettype none

`include "nibble_params.svh"

package alu_pkg;

    // opcodes understood by the 4-bit ALU
    typedef enum logic [2:0] {
        ADD    = 3'd0,
        AND_OP = 3'd1,
        OR_OP  = 3'd2,
        XOR_OP = 3'd3,
        RSHFT  = 3'd4
    } alu_cmd;

    // one nibble step into the ALU
    typedef struct packed {
        alu_cmd                cmd;
        // carry for ADD, incoming top bit for RSHFT
        logic                  carry_in;
        logic [`NIBBLE_W-1:0]  d1;
        logic [`NIBBLE_W-1:0]  d2;
    } alu_args;

    // one nibble step out of the ALU
    typedef struct packed {
        logic [`NIBBLE_W-1:0]  res;
        // ADD carry or bit shifted out of the nibble
        logic                  carry_out;
    } alu_ret;

endpackage

`default_nettype wire

// File: hdl/op_pkg.sv
// Word operation types
`default_nettype none

`include "nibble_params.svh"

package op_pkg;

    // controller states
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        RUN  = 2'd1,
        DONE = 2'd2
    } op_state;

    // request captured on an accepted start
    typedef struct packed {
        alu_pkg::alu_cmd       cmd;
        logic [`IDX_W-1:0]     last_idx;
        logic [`WORD_W-1:0]    word1;
        logic [`WORD_W-1:0]    word2;
        // nibbles the operation does not reach keep this value
        logic [`WORD_W-1:0]    preinit;
    } op_request;

endpackage

`default_nettype wire

// File: hdl/nibble_alu_if.sv
// Nibble ALU step bus
`default_nettype none

interface nibble_alu_if;

    // command, carry and operand nibbles from the loop
    alu_pkg::alu_args args;

    // result nibble and carry back from the ALU
    alu_pkg::alu_ret ret;

    // loop drives the step and reads the answer
    modport loop_side (
        output args,
        input  ret
    );

    // ALU reads the step and answers within the same cycle
    modport alu_side (
        input  args,
        output ret
    );

endinterface

`default_nettype wire

// File: hdl/nibble_alu.sv
// Combinational nibble ALU
`default_nettype none

`include "nibble_params.svh"

module nibble_alu (
    nibble_alu_if.alu_side alu
);

    // 5-bit sum, top bit is the carry out
    logic [`NIBBLE_W:0] sum;
    alu_pkg::alu_ret ret;

    assign sum = {1'b0, alu.args.d1}
               + {1'b0, alu.args.d2}
               + {{`NIBBLE_W{1'b0}}, alu.args.carry_in};

    always_comb begin
        ret = '0;
        case (alu.args.cmd)
            alu_pkg::ADD: begin
                ret.res       = sum[`NIBBLE_W-1:0];
                ret.carry_out = sum[`NIBBLE_W];
            end
            alu_pkg::AND_OP: begin
                ret.res = alu.args.d1 & alu.args.d2;
            end
            alu_pkg::OR_OP: begin
                ret.res = alu.args.d1 | alu.args.d2;
            end
            alu_pkg::XOR_OP: begin
                ret.res = alu.args.d1 ^ alu.args.d2;
            end
            alu_pkg::RSHFT: begin
                // bit from the nibble above enters at the top
                ret.res       = {alu.args.carry_in, alu.args.d2[`NIBBLE_W-1:1]};
                ret.carry_out = alu.args.d2[0];
            end
            default: begin
                ret = '0;
            end
        endcase
    end

    assign alu.ret = ret;

endmodule

`default_nettype wire

// File: hdl/nibble_loop.sv
// Nibble loop over one word
`default_nettype none

`include "nibble_params.svh"

module nibble_loop (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  loop_run,
    input  var op_pkg::op_request req,
    output logic                 loop_busy,
    output logic [`WORD_W-1:0]   result,
    nibble_alu_if.loop_side      alu
);

    // RSHFT walks from the last index down to nibble 0
    logic                reverse;
    // extra top bit flags overflow past nibble 7 or below nibble 0
    logic [`IDX_W:0]     counter;
    logic [`IDX_W:0]     counter_next;
    logic [`IDX_W-1:0]   idx;
    logic                started;
    logic                passed_last;
    logic                carry;
    logic                at_last;
    logic                final_step;
    logic                step_en;

    assign reverse      = (req.cmd == alu_pkg::RSHFT);
    assign idx          = counter[`IDX_W-1:0];
    assign counter_next = reverse ? counter - 1'b1 : counter + 1'b1;
    assign at_last      = reverse ? (idx == '0) : (idx == req.last_idx);

    // this cycle writes the last nibble of the operation
    assign final_step = ((at_last || passed_last) && !alu.ret.carry_out)
                      || counter_next[`IDX_W];
    assign step_en    = loop_run && started;

    // high through the init cycle and every nibble but the final one
    assign loop_busy  = loop_run && !(started && final_step);

    // feed the indexed nibbles to the ALU
    assign alu.args.cmd      = req.cmd;
    assign alu.args.carry_in = carry;
    assign alu.args.d1       = req.word1[(`NIBBLE_W * idx) +: `NIBBLE_W];
    assign alu.args.d2       = req.word2[(`NIBBLE_W * idx) +: `NIBBLE_W];

    // first run cycle is the init cycle
    always_ff @(posedge clk) begin
        if (reset || !loop_run) begin
            started <= 1'b0;
        end else begin
            started <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            counter     <= '0;
            carry       <= 1'b0;
            passed_last <= 1'b0;
        end else if (loop_run && !started) begin
            counter     <= reverse ? {1'b0, req.last_idx} : '0;
            carry       <= 1'b0;
            passed_last <= 1'b0;
        end else if (step_en) begin
            counter <= counter_next;
            // carry for ADD, shifted-out bit for RSHFT
            carry   <= alu.ret.carry_out;
            if (at_last) begin
                passed_last <= 1'b1;
            end
        end
    end

    // untouched nibbles keep the preinit value
    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
        end else if (loop_run && !started) begin
            result <= req.preinit;
        end else if (step_en) begin
            result[(`NIBBLE_W * idx) +: `NIBBLE_W] <= alu.ret.res;
        end
    end

endmodule

`default_nettype wire

// File: hdl/op_control.sv
// Word operation controller
`default_nettype none

`include "nibble_params.svh"

module op_control (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   start,
    input  var alu_pkg::alu_cmd   cmd,
    input  wire [`IDX_W-1:0]      last_idx,
    input  wire [`WORD_W-1:0]     word1,
    input  wire [`WORD_W-1:0]     word2,
    input  wire [`WORD_W-1:0]     preinit,
    input  wire                   loop_busy,
    output op_pkg::op_request     req,
    output logic                  loop_run,
    output logic                  busy,
    output logic                  done
);

    op_pkg::op_state state;
    logic accept;

    // start only counts outside a run, DONE allows back-to-back
    assign accept = start && (state != op_pkg::RUN);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= op_pkg::IDLE;
        end else begin
            case (state)
                op_pkg::RUN: begin
                    // loop signals its final nibble, done follows next cycle
                    if (!loop_busy) begin
                        state <= op_pkg::DONE;
                    end
                end
                default: begin
                    state <= accept ? op_pkg::RUN : op_pkg::IDLE;
                end
            endcase
        end
    end

    // request stays stable for the whole run
    always_ff @(posedge clk) begin
        if (accept) begin
            req.cmd      <= cmd;
            req.last_idx <= last_idx;
            req.word1    <= word1;
            req.word2    <= word2;
            req.preinit  <= preinit;
        end
    end

    assign loop_run = (state == op_pkg::RUN);
    assign busy     = (state == op_pkg::RUN);
    // DONE lasts exactly one cycle
    assign done     = (state == op_pkg::DONE);

endmodule

`default_nettype wire

// File: hdl/nibble_serial_alu.sv
// Nibble-serial ALU top level
`default_nettype none

`include "nibble_params.svh"

module nibble_serial_alu (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  start,
    input  var alu_pkg::alu_cmd  cmd,
    input  wire [`IDX_W-1:0]     last_idx,
    input  wire [`WORD_W-1:0]    word1,
    input  wire [`WORD_W-1:0]    word2,
    input  wire [`WORD_W-1:0]    preinit,
    output wire                  busy,
    output wire                  done,
    output wire [`WORD_W-1:0]    result
);

    op_pkg::op_request req;
    wire loop_run;
    wire loop_busy;

    // one nibble step between loop and ALU
    nibble_alu_if alu_bus ();

    op_control u_control (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .cmd       (cmd),
        .last_idx  (last_idx),
        .word1     (word1),
        .word2     (word2),
        .preinit   (preinit),
        .loop_busy (loop_busy),
        .req       (req),
        .loop_run  (loop_run),
        .busy      (busy),
        .done      (done)
    );

    nibble_loop u_loop (
        .clk       (clk),
        .reset     (reset),
        .loop_run  (loop_run),
        .req       (req),
        .loop_busy (loop_busy),
        .result    (result),
        .alu       (alu_bus)
    );

    nibble_alu u_alu (
        .alu (alu_bus)
    );

endmodule

`default_nettype wire

// File: bench/nibble_serial_alu_sva.sv
// Nibble-serial ALU protocol checks
`default_nettype none

`include "nibble_params.svh"

module nibble_serial_alu_sva (
    input wire              clk,
    input wire              reset,
    input wire              start,
    input wire [`IDX_W-1:0] last_idx,
    input wire              busy,
    input wire              done
);

    // busy cycles seen so far in the current run
    int                 busy_len;
    // last index of the accepted request
    logic [`IDX_W-1:0]  op_last;
    int                 error_count = 0;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_len <= 0;
            op_last  <= '0;
        end else begin
            busy_len <= busy ? busy_len + 1 : 0;
            if (start && !busy) begin
                op_last <= last_idx;
            end
        end
    end

    done_single_cycle: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
        else begin
            $error("done lasted more than one cycle");
            error_count++;
        end

    done_after_busy_fall: assert property (@(posedge clk) disable iff (reset)
        done |-> ($past(busy) && !busy))
        else begin
            $error("done without busy falling in the cycle before");
            error_count++;
        end

    busy_min_length: assert property (@(posedge clk) disable iff (reset)
        $fell(busy) |-> (busy_len >= int'(op_last) + 2))
        else begin
            $error("busy fell before last_idx+2 cycles");
            error_count++;
        end

    busy_max_length: assert property (@(posedge clk) disable iff (reset)
        busy |-> (busy_len < 10))
        else begin
            $error("busy stayed high for more than 10 cycles");
            error_count++;
        end

endmodule

bind nibble_serial_alu nibble_serial_alu_sva u_sva (
    .clk      (clk),
    .reset    (reset),
    .start    (start),
    .last_idx (last_idx),
    .busy     (busy),
    .done     (done)
);

`default_nettype wire

// File: bench/nibble_serial_alu_tb.sv
// Nibble-serial ALU testbench
`default_nettype none

`include "nibble_params.svh"

module nibble_serial_alu_tb;

    localparam int N_OPS = 200;
    localparam int N_RANDOM = 192;
    // reset plus at most 12 cycles for every operation
    localparam int TIMEOUT_CYCLES = 5 + 12 * N_OPS;

    logic                clk;
    logic                reset;
    logic                start;
    alu_pkg::alu_cmd     cmd;
    logic [`IDX_W-1:0]   last_idx;
    logic [`WORD_W-1:0]  word1;
    logic [`WORD_W-1:0]  word2;
    logic [`WORD_W-1:0]  preinit;
    wire                 busy;
    wire                 done;
    wire [`WORD_W-1:0]   result;
    logic [31:0]         rng;
    int                  cycles = 0;

    nibble_serial_alu UUT (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .cmd      (cmd),
        .last_idx (last_idx),
        .word1    (word1),
        .word2    (word2),
        .preinit  (preinit),
        .busy     (busy),
        .done     (done),
        .result   (result)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // expected word built nibble by nibble from the operation rules
    function automatic logic [`WORD_W-1:0] model_result(input alu_pkg::alu_cmd c,
            input logic [`IDX_W-1:0] k, input logic [`WORD_W-1:0] w1,
            input logic [`WORD_W-1:0] w2, input logic [`WORD_W-1:0] p);
        logic [`WORD_W-1:0] mask;
        logic [`WORD_W-1:0] r;
        logic [`NIBBLE_W:0] t;
        logic               cy;
        int                 i;
        // ones over nibbles 0 through k
        mask = {`WORD_W{1'b1}} >> (`NIBBLE_W * (`NIBBLE_CNT - 1 - int'(k)));
        r = p & ~mask;
        cy = 1'b0;
        case (c)
            alu_pkg::ADD: begin
                r = p;
                for (i = 0; i < `NIBBLE_CNT; i++) begin
                    // past k only while a carry is still pending
                    if (i <= int'(k) || cy) begin
                        t = w1[`NIBBLE_W*i +: `NIBBLE_W] + w2[`NIBBLE_W*i +: `NIBBLE_W] + cy;
                        r[`NIBBLE_W*i +: `NIBBLE_W] = t[`NIBBLE_W-1:0];
                        cy = t[`NIBBLE_W];
                    end
                end
            end
            alu_pkg::AND_OP: r = r | (w1 & w2 & mask);
            alu_pkg::OR_OP:  r = r | ((w1 | w2) & mask);
            alu_pkg::XOR_OP: r = r | ((w1 ^ w2) & mask);
            // zero enters at the top of the shifted field
            alu_pkg::RSHFT:  r = r | ((w2 & mask) >> 1);
            default:         r = p;
        endcase
        return r;
    endfunction

    task automatic check_result(input string name, input logic [`WORD_W-1:0] exp_val);
        assert (result === exp_val) else begin
            $display("FAIL %s expected %h actual %h", name, exp_val, result);
            $display("** FAIL **");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic wait_done(input string name, input logic [`WORD_W-1:0] exp_val);
        @(negedge clk);
        while (done !== 1'b1) begin
            @(negedge clk);
        end
        check_result(name, exp_val);
    endtask

    task automatic drive_request(input alu_pkg::alu_cmd c, input logic [`IDX_W-1:0] k,
            input logic [`WORD_W-1:0] w1, input logic [`WORD_W-1:0] w2,
            input logic [`WORD_W-1:0] p);
        cmd      <= c;
        last_idx <= k;
        word1    <= w1;
        word2    <= w2;
        preinit  <= p;
    endtask

    task automatic run_op(input string name, input alu_pkg::alu_cmd c,
            input logic [`IDX_W-1:0] k, input logic [`WORD_W-1:0] w1,
            input logic [`WORD_W-1:0] w2, input logic [`WORD_W-1:0] p);
        logic [`WORD_W-1:0] exp_val;
        exp_val = model_result(c, k, w1, w2, p);
        @(posedge clk);
        drive_request(c, k, w1, w2, p);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        wait_done(name, exp_val);
    endtask

    // watchdog and bound checker monitor
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout, the operations did not finish within %0d cycles",
                     TIMEOUT_CYCLES);
            $display("** FAIL **");
            $fatal(1, "watchdog expired");
        end else if (UUT.u_sva.error_count != 0) begin
            $display("a protocol assertion on busy or done failed");
            $display("** FAIL **");
            $fatal(1, "protocol assertion failed");
        end
    end

    initial begin
        alu_pkg::alu_cmd     c;
        string               name;
        logic [15:0]         sel;
        logic [`IDX_W-1:0]   k;
        logic [`WORD_W-1:0]  w1;
        logic [`WORD_W-1:0]  w2;
        logic [`WORD_W-1:0]  p;
        logic [`WORD_W-1:0]  exp_first;
        logic [`WORD_W-1:0]  exp_second;
        reset = 1'b1;
        start = 1'b0;
        cmd = alu_pkg::ADD;
        last_idx = '0;
        word1 = '0;
        word2 = '0;
        preinit = '0;
        rng = 32'ha63fd29c;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (busy === 1'b0 && done === 1'b0) else begin
            $display("FAIL reset_state expected busy 0 done 0 actual busy %b done %b",
                     busy, done);
            $display("** FAIL **");
            $fatal(1, "reset state");
        end
        check_result("reset_state", '0);

        // directed corners
        run_op("add_last0", alu_pkg::ADD, 3'd0, 32'h0000_000f, 32'h0000_0001, 32'h0);
        run_op("add_carry_drop", alu_pkg::ADD, 3'd0, 32'hffff_ffff, 32'h1, 32'h1234_5678);
        run_op("add_preinit_ones", alu_pkg::ADD, 3'd3, 32'h1234, 32'h4321, 32'hffff_ffff);
        run_op("xor_preinit_zero", alu_pkg::XOR_OP, 3'd0, 32'ha5a5_a5a5, 32'hffff_ffff, 32'h0);
        run_op("rshift_full", alu_pkg::RSHFT, 3'd7, 32'h0, 32'h8000_0001, 32'h0);
        run_op("rshift_last0", alu_pkg::RSHFT, 3'd0, 32'h0, 32'h0000_000f, 32'hffff_ffff);

        // second request held on start while the first one runs
        exp_first = model_result(alu_pkg::XOR_OP, 3'd5, 32'h1357_9bdf, 32'h0f0f_0f0f,
                                 32'hffff_ffff);
        exp_second = model_result(alu_pkg::ADD, 3'd7, 32'h89ab_cdef, 32'h7654_3211,
                                  32'h0);
        @(posedge clk);
        drive_request(alu_pkg::XOR_OP, 3'd5, 32'h1357_9bdf, 32'h0f0f_0f0f, 32'hffff_ffff);
        start <= 1'b1;
        @(posedge clk);
        drive_request(alu_pkg::ADD, 3'd7, 32'h89ab_cdef, 32'h7654_3211, 32'h0);
        wait_done("busy_hold", exp_first);
        // start is still high in the done cycle
        @(posedge clk);
        start <= 1'b0;
        wait_done("back_to_back", exp_second);

        repeat (N_RANDOM) begin
            rng = lcg_step(rng);
            sel = rng[31:16] % 16'd5;
            c = alu_pkg::alu_cmd'(sel[2:0]);
            k = rng[14:12];
            rng = lcg_step(rng);
            w1 = rng;
            rng = lcg_step(rng);
            w2 = rng;
            rng = lcg_step(rng);
            p = rng;
            case (c)
                alu_pkg::ADD:   name = "add_random";
                alu_pkg::RSHFT: name = "rshift_random";
                default:        name = "logic_random";
            endcase
            run_op(name, c, k, w1, w2, p);
        end

        // let the checks on the last done pulse complete
        repeat (2) @(negedge clk);
        if (UUT.u_sva.error_count != 0) begin
            $display("a protocol assertion on busy or done failed");
            $display("** FAIL **");
            $fatal(1, "protocol assertion failed");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: nibble_serial_alu.f
+incdir+hdl
hdl/alu_pkg.sv
hdl/op_pkg.sv
hdl/nibble_alu_if.sv
hdl/nibble_alu.sv
hdl/nibble_loop.sv
hdl/op_control.sv
hdl/nibble_serial_alu.sv
bench/nibble_serial_alu_sva.sv
bench/nibble_serial_alu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the nibble-serial ALU testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f nibble_serial_alu.f \
    --top-module nibble_serial_alu_tb -o sim_tb || { echo "build failed"; exit 1; }
./obj_dir/sim_tb +verilator+error+limit+100 > sim.log 2>&1
grep -qF "** FAIL **" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -qF "** PASS **" sim.log || { echo "no pass message in sim.log"; exit 1; }
echo "simulation passed"
